// File: common/vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// AXI4-Lite bus
`define VGA_AXIL_ADDR_W   12
`define VGA_AXIL_DATA_W   32
`define VGA_NATIVE_ADDR_W 2   // four word registers

// horizontal timing in pixel clocks
`define VGA_H_ACTIVE 16
`define VGA_H_FP     2
`define VGA_H_SYNC   4
`define VGA_H_BP     2
`define VGA_H_TOTAL  (`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC + `VGA_H_BP)

// vertical timing in lines
`define VGA_V_ACTIVE 8
`define VGA_V_FP     1
`define VGA_V_SYNC   2
`define VGA_V_BP     1
`define VGA_V_TOTAL  (`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC + `VGA_V_BP)

// coordinate widths follow the totals
`define VGA_X_W $clog2(`VGA_H_TOTAL)
`define VGA_Y_W $clog2(`VGA_V_TOTAL)

`define VGA_COLOR_W     4
`define VGA_FRAME_CNT_W 16

`endif

// File: common/vga_pkg.sv
`include "vga_macros.svh"

package vga_pkg;

  typedef logic [`VGA_AXIL_ADDR_W-1:0]   axil_addr_t;
  typedef logic [`VGA_AXIL_DATA_W-1:0]   axil_data_t;
  typedef logic [`VGA_NATIVE_ADDR_W-1:0] native_addr_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // word addresses, byte address is four times these
  localparam native_addr_t REG_CTRL   = native_addr_t'(0);
  localparam native_addr_t REG_FG     = native_addr_t'(1);
  localparam native_addr_t REG_BG     = native_addr_t'(2);
  localparam native_addr_t REG_STATUS = native_addr_t'(3);

  typedef struct packed {
    logic [`VGA_AXIL_DATA_W-3*`VGA_COLOR_W-1:0] unused;
    logic [`VGA_COLOR_W-1:0]                    red;
    logic [`VGA_COLOR_W-1:0]                    green;
    logic [`VGA_COLOR_W-1:0]                    blue;
  } color_view_t;

  typedef struct packed {
    logic [`VGA_AXIL_DATA_W-3:0] unused;
    logic                        pattern;  // 0 solid, 1 checker
    logic                        enable;
  } ctrl_view_t;

  // the same data word decoded by register address
  typedef union packed {
    color_view_t color;
    ctrl_view_t  ctrl;
  } reg_word_u;

  // byte address to word address, upper bits alias
  function automatic native_addr_t to_native_addr(axil_addr_t addr);
    return addr[`VGA_NATIVE_ADDR_W+1:2];
  endfunction

endpackage

// File: axil/vga_axil_slave_fsm.sv
`timescale 1ns/100ps

module vga_axil_slave_fsm (
  input  logic                  clk_if,
  input  logic                  arst_n,

  input  vga_pkg::axil_addr_t   awaddr,
  input  logic                  awvalid,
  output logic                  awready,

  input  vga_pkg::axil_data_t   wdata,
  input  logic                  wvalid,
  output logic                  wready,

  output vga_pkg::axil_resp_e   bresp,
  output logic                  bvalid,
  input  logic                  bready,

  input  vga_pkg::axil_addr_t   araddr,
  input  logic                  arvalid,
  output logic                  arready,

  output vga_pkg::axil_data_t   rdata,
  output vga_pkg::axil_resp_e   rresp,
  output logic                  rvalid,
  input  logic                  rready,

  output vga_pkg::native_addr_t waddr,
  output vga_pkg::axil_data_t   wdata_native,
  output logic                  write_en,
  output vga_pkg::native_addr_t raddr,
  output logic                  read_en,
  input  vga_pkg::axil_data_t   rdata_native
);

  import vga_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_STROBE,
    ST_WR_RESP,
    ST_RD_STROBE,
    ST_RD_WAIT,
    ST_RD_RESP
  } state_e;

  state_e state;
  state_e state_next;
  logic   write_req;
  logic   wr_accept;
  logic   rd_accept;

  assign write_req = awvalid && wvalid;  // address and data must arrive together
  assign wr_accept = (state == ST_IDLE) && write_req;
  assign rd_accept = (state == ST_IDLE) && !write_req && arvalid;  // writes win a tie

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  assign write_en = (state == ST_WR_STROBE);
  assign read_en  = (state == ST_RD_STROBE);
  assign bvalid   = (state == ST_WR_RESP);
  assign rvalid   = (state == ST_RD_RESP);

  assign bresp = OKAY;
  assign rresp = OKAY;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (wr_accept) begin
          state_next = ST_WR_STROBE;
        end else if (rd_accept) begin
          state_next = ST_RD_STROBE;
        end
      end
      ST_WR_STROBE: state_next = ST_WR_RESP;
      ST_WR_RESP: begin
        if (bready) begin
          state_next = ST_IDLE;
        end
      end
      ST_RD_STROBE: state_next = ST_RD_WAIT;  // register file answers next cycle
      ST_RD_WAIT:   state_next = ST_RD_RESP;
      ST_RD_RESP: begin
        if (rready) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      waddr        <= '0;
      wdata_native <= '0;
      raddr        <= '0;
      rdata        <= '0;
    end else begin
      if (wr_accept) begin
        waddr        <= to_native_addr(awaddr);
        wdata_native <= wdata;
      end
      if (rd_accept) begin
        raddr <= to_native_addr(araddr);
      end
      if (state == ST_RD_WAIT) begin
        rdata <= rdata_native;  // held for the whole response phase
      end
    end
  end

endmodule

// File: hdl/vga_regfile.sv
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_regfile (
  input  logic                          clk_if,
  input  logic                          arst_n,
  input  logic                          write_en,
  input  vga_pkg::native_addr_t         waddr,
  input  vga_pkg::axil_data_t           wdata_native,
  input  logic                          read_en,
  input  vga_pkg::native_addr_t         raddr,
  input  logic                          frame_start,
  output vga_pkg::axil_data_t           rdata_native,
  output logic                          ctrl_enable,
  output logic                          ctrl_pattern,
  output logic [3*`VGA_COLOR_W-1:0]     fg_color,
  output logic [3*`VGA_COLOR_W-1:0]     bg_color,
  output logic [`VGA_FRAME_CNT_W-1:0]   frame_count
);

  import vga_pkg::*;

  reg_word_u wr_word;
  reg_word_u rd_word;

  assign wr_word = wdata_native;

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_enable  <= 1'b0;
      ctrl_pattern <= 1'b0;
      fg_color     <= '0;
      bg_color     <= '0;
    end else if (write_en) begin
      case (waddr)
        REG_CTRL: begin
          ctrl_enable  <= wr_word.ctrl.enable;
          ctrl_pattern <= wr_word.ctrl.pattern;
        end
        REG_FG: fg_color <= {wr_word.color.red, wr_word.color.green, wr_word.color.blue};
        REG_BG: bg_color <= {wr_word.color.red, wr_word.color.green, wr_word.color.blue};
        default: ;  // status is read only
      endcase
    end
  end

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      frame_count <= '0;
    end else if (frame_start) begin
      frame_count <= frame_count + 1'b1;
    end
  end

  always_comb begin
    rd_word = '0;
    case (raddr)
      REG_CTRL: begin
        rd_word.ctrl.enable  = ctrl_enable;
        rd_word.ctrl.pattern = ctrl_pattern;
      end
      REG_FG: {rd_word.color.red, rd_word.color.green, rd_word.color.blue} = fg_color;
      REG_BG: {rd_word.color.red, rd_word.color.green, rd_word.color.blue} = bg_color;
      default: rd_word = axil_data_t'(frame_count);
    endcase
  end

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      rdata_native <= '0;
    end else if (read_en) begin
      rdata_native <= rd_word;
    end
  end

endmodule

// File: video/vga_timing.sv
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_timing (
  input  logic                 clk_if,
  input  logic                 arst_n,
  input  logic                 enable,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 de,
  output logic [`VGA_X_W-1:0]  x,
  output logic [`VGA_Y_W-1:0]  y,
  output logic                 frame_start
);

  typedef logic [`VGA_X_W-1:0] x_t;
  typedef logic [`VGA_Y_W-1:0] y_t;

  // each line and frame runs active, front porch, sync, back porch
  localparam x_t H_ACTIVE     = x_t'(`VGA_H_ACTIVE);
  localparam x_t H_SYNC_START = x_t'(`VGA_H_ACTIVE + `VGA_H_FP);
  localparam x_t H_SYNC_END   = x_t'(`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC);
  localparam x_t H_LAST       = x_t'(`VGA_H_TOTAL - 1);

  localparam y_t V_ACTIVE     = y_t'(`VGA_V_ACTIVE);
  localparam y_t V_SYNC_START = y_t'(`VGA_V_ACTIVE + `VGA_V_FP);
  localparam y_t V_SYNC_END   = y_t'(`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC);
  localparam y_t V_LAST       = y_t'(`VGA_V_TOTAL - 1);

  x_t h_cnt;
  y_t v_cnt;

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable) begin
      h_cnt <= '0;  // parked at the first pixel while off
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      if (v_cnt == V_LAST) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
  assign vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
  assign de    = enable && (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

  // first cycle of the first sync line
  assign frame_start = enable && (v_cnt == V_SYNC_START) && (h_cnt == '0);

  assign x = h_cnt;
  assign y = v_cnt;

endmodule

// File: video/vga_pixel_gen.sv
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_pixel_gen (
  input  logic                       clk_if,
  input  logic                       arst_n,
  input  logic                       hsync_in,
  input  logic                       vsync_in,
  input  logic                       de_in,
  input  logic [`VGA_X_W-1:0]        x,
  input  logic [`VGA_Y_W-1:0]        y,
  input  logic                       pattern,
  input  logic [3*`VGA_COLOR_W-1:0]  fg_color,
  input  logic [3*`VGA_COLOR_W-1:0]  bg_color,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       de,
  output logic [`VGA_COLOR_W-1:0]    red,
  output logic [`VGA_COLOR_W-1:0]    green,
  output logic [`VGA_COLOR_W-1:0]    blue
);

  logic                      use_fg;
  logic [3*`VGA_COLOR_W-1:0] pixel_color;

  // checker squares are two pixels on a side
  assign use_fg      = pattern && (x[1] ^ y[1]);
  assign pixel_color = de_in ? (use_fg ? fg_color : bg_color) : '0;

  always_ff @(posedge clk_if or negedge arst_n) begin
    if (!arst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      de    <= 1'b0;
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      hsync <= hsync_in;  // syncs follow the colour by one stage
      vsync <= vsync_in;
      de    <= de_in;
      {red, green, blue} <= pixel_color;
    end
  end

endmodule

// File: hdl/vga_axil_top.sv
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_axil_top (
  input  logic                     clk_if,
  input  logic                     arst_n,
  input  vga_pkg::axil_addr_t      awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  vga_pkg::axil_data_t      wdata,
  input  logic                     wvalid,
  output logic                     wready,
  output vga_pkg::axil_resp_e      bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  vga_pkg::axil_addr_t      araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output vga_pkg::axil_data_t      rdata,
  output vga_pkg::axil_resp_e      rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic                     hsync,
  output logic                     vsync,
  output logic                     de,
  output logic [`VGA_COLOR_W-1:0]  red,
  output logic [`VGA_COLOR_W-1:0]  green,
  output logic [`VGA_COLOR_W-1:0]  blue
);

  import vga_pkg::*;

  native_addr_t              waddr;
  native_addr_t              raddr;
  axil_data_t                wdata_native;
  axil_data_t                rdata_native;
  logic                      write_en;
  logic                      read_en;
  logic                      ctrl_enable;
  logic                      ctrl_pattern;
  logic [3*`VGA_COLOR_W-1:0] fg_color;
  logic [3*`VGA_COLOR_W-1:0] bg_color;
  logic                      frame_start;
  logic                      tim_hsync;
  logic                      tim_vsync;
  logic                      tim_de;
  logic [`VGA_X_W-1:0]       x;
  logic [`VGA_Y_W-1:0]       y;

  vga_axil_slave_fsm i_slave_fsm (
    .clk_if, .arst_n,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .waddr, .wdata_native, .write_en,
    .raddr, .read_en, .rdata_native
  );

  vga_regfile i_regfile (
    .clk_if, .arst_n,
    .write_en, .waddr, .wdata_native,
    .read_en, .raddr, .rdata_native,
    .frame_start,
    .ctrl_enable, .ctrl_pattern,
    .fg_color, .bg_color,
    .frame_count ()  // only seen over the bus as the status register
  );

  vga_timing i_timing (
    .clk_if, .arst_n,
    .enable      (ctrl_enable),
    .hsync       (tim_hsync),
    .vsync       (tim_vsync),
    .de          (tim_de),
    .x, .y,
    .frame_start
  );

  vga_pixel_gen i_pixel_gen (
    .clk_if, .arst_n,
    .hsync_in    (tim_hsync),
    .vsync_in    (tim_vsync),
    .de_in       (tim_de),
    .x, .y,
    .pattern     (ctrl_pattern),
    .fg_color, .bg_color,
    .hsync, .vsync, .de,
    .red, .green, .blue
  );

endmodule

// File: testbench/tb_vga_axil_top.sv
`timescale 1ns/100ps
`include "vga_macros.svh"

module tb_vga_axil_top;

  import vga_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int CYCLE_LIMIT  = 4000;  // about six frames plus bus traffic, doubled
  localparam int LINE_CYCLES  = `VGA_H_TOTAL;
  localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                    clk_if;
  logic                    arst_n;
  axil_addr_t              awaddr;
  logic                    awvalid;
  logic                    awready;
  axil_data_t              wdata;
  logic                    wvalid;
  logic                    wready;
  axil_resp_e              bresp;
  logic                    bvalid;
  logic                    bready;
  axil_addr_t              araddr;
  logic                    arvalid;
  logic                    arready;
  axil_data_t              rdata;
  axil_resp_e              rresp;
  logic                    rvalid;
  logic                    rready;
  logic                    hsync;
  logic                    vsync;
  logic                    de;
  logic [`VGA_COLOR_W-1:0] red;
  logic [`VGA_COLOR_W-1:0] green;
  logic [`VGA_COLOR_W-1:0] blue;

  int          err_cnt     = 0;
  int          check_cnt   = 0;
  int          test_cnt    = 0;
  int          cycle_cnt   = 0;
  int          vsync_falls = 0;
  logic        vsync_prev  = 1'b1;
  logic [31:0] lfsr_state  = 32'haad8;

  vga_axil_top i_dut (.*);

  initial begin
    clk_if = 1'b0;
    forever #CLK_HALF clk_if = ~clk_if;
  end

  always @(posedge clk_if) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  always @(negedge clk_if) begin
    if (vsync_prev && !vsync) begin
      vsync_falls = vsync_falls + 1;  // outputs move on posedge so negedge sees them settled
    end
    vsync_prev = vsync;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < nbits; i++) begin
      word = {word[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return word;
  endfunction

  function automatic axil_addr_t byte_addr(input native_addr_t reg_addr);
    return axil_addr_t'({reg_addr, 2'b00});
  endfunction

  function automatic logic sync_sel(input logic use_vsync);
    return use_vsync ? vsync : hsync;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt = check_cnt + 1;
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t %s: got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt = test_cnt + 1;
    $display("test %-16s %s", name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // hold > 0 keeps bready low that many cycles while a read competes for the bus
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold);
    @(negedge clk_if);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b0;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk_if);
      #1;
    end
    @(negedge clk_if);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk_if);
    check("bresp", 32'(bresp), 32'(RESP_OKAY));
    for (int held = 0; held < hold; held++) begin
      araddr  = byte_addr(REG_STATUS);
      arvalid = 1'b1;
      #1;
      check("bvalid", 32'(bvalid), 1);
      check("arready", 32'(arready), 0);
      @(negedge clk_if);
    end
    arvalid = 1'b0;
    bready  = 1'b1;
    @(negedge clk_if);
    bready = 1'b0;
    check("bvalid", 32'(bvalid), 0);
  endtask

  // hold > 0 keeps rready low that many cycles while a write competes for the bus
  task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
    @(negedge clk_if);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    #1;
    while (!arready) begin
      @(negedge clk_if);
      #1;
    end
    @(negedge clk_if);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_if);
    check("rresp", 32'(rresp), 32'(RESP_OKAY));
    data = rdata;
    for (int held = 0; held < hold; held++) begin
      awaddr  = byte_addr(REG_STATUS);
      wdata   = '0;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      #1;
      check("rvalid", 32'(rvalid), 1);
      check("rdata", rdata, data);
      check("awready", 32'(awready), 0);
      check("wready", 32'(wready), 0);
      @(negedge clk_if);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(negedge clk_if);
    rready = 1'b0;
    check("rvalid", 32'(rvalid), 0);
  endtask

  // returns at the negedge where the chosen sync is first seen low
  task automatic wait_sync_fall(input logic use_vsync);
    logic prev;
    @(negedge clk_if);
    prev = sync_sel(use_vsync);
    @(negedge clk_if);
    while (!(prev && !sync_sel(use_vsync))) begin
      prev = sync_sel(use_vsync);
      @(negedge clk_if);
    end
  endtask

  task automatic measure_sync(input logic use_vsync, output int low_w, output int period);
    wait_sync_fall(use_vsync);
    low_w  = 0;
    period = 0;
    while (!sync_sel(use_vsync)) begin
      low_w  = low_w + 1;
      period = period + 1;
      @(negedge clk_if);
    end
    while (sync_sel(use_vsync)) begin
      period = period + 1;
      @(negedge clk_if);
    end
  endtask

  // walks one frame from a vsync fall, tracking x and y from de
  task automatic scan_frame(input logic checker_on, input logic [11:0] fg,
                            input logic [11:0] bg);
    int          px;
    int          ln;
    logic [11:0] exp;
    px = 0;
    ln = 0;
    for (int i = 0; i < FRAME_CYCLES; i++) begin
      if (de) begin
        exp = (checker_on && (px[1] ^ ln[1])) ? fg : bg;
        px  = px + 1;
      end else begin
        exp = '0;
        if (px != 0) begin
          check("de width", px, `VGA_H_ACTIVE);
          ln = ln + 1;
          px = 0;
        end
      end
      check("rgb", 32'({red, green, blue}), 32'(exp));
      @(negedge clk_if);
    end
    check("active lines", ln, `VGA_V_ACTIVE);
  endtask

  task automatic test_readback();
    axil_data_t ctrl_w;
    axil_data_t fg_w;
    axil_data_t bg_w;
    axil_data_t got;
    int         errs;
    errs = err_cnt;
    check("hsync idle", 32'(hsync), 1);
    check("vsync idle", 32'(vsync), 1);
    check("de idle", 32'(de), 0);
    check("rgb idle", 32'({red, green, blue}), 0);
    ctrl_w = random_bits(32) & ~32'h1;  // video stays off
    fg_w   = random_bits(32);
    bg_w   = random_bits(32);
    axil_write(byte_addr(REG_CTRL), ctrl_w, 0);
    axil_write(byte_addr(REG_FG), fg_w, 0);
    axil_write(byte_addr(REG_BG), bg_w, 0);
    axil_read(byte_addr(REG_CTRL), 0, got);
    check("rdata ctrl", got, {30'b0, ctrl_w[1:0]});
    axil_read(byte_addr(REG_FG), 0, got);
    check("rdata fg", got, {20'b0, fg_w[11:0]});
    axil_read(byte_addr(REG_BG), 0, got);
    check("rdata bg", got, {20'b0, bg_w[11:0]});
    check("de disabled", 32'(de), 0);
    report_test("readback", errs);
  endtask

  task automatic test_alias_status();
    axil_data_t w;
    axil_data_t got;
    axil_data_t s0;
    int         errs;
    errs = err_cnt;
    w = random_bits(32);
    axil_write(byte_addr(REG_BG), w, 0);
    axil_read(12'hA0B, 0, got);  // bits 3:2 pick the bg register
    check("rdata alias", got, {20'b0, w[11:0]});
    axil_read(byte_addr(REG_STATUS), 0, s0);
    check("rdata status", s0, 0);
    axil_write(byte_addr(REG_STATUS), random_bits(32), 0);
    axil_read(byte_addr(REG_STATUS), 0, got);
    check("rdata status kept", got, 0);
    report_test("alias status", errs);
  endtask

  task automatic test_backpressure();
    axil_data_t w;
    axil_data_t got;
    int         errs;
    errs = err_cnt;
    w = random_bits(32);
    axil_write(byte_addr(REG_FG), w, 5);
    axil_read(byte_addr(REG_FG), 5, got);
    check("rdata fg", got, {20'b0, w[11:0]});
    report_test("backpressure", errs);
  endtask

  task automatic test_sync_timing();
    axil_data_t bg_w;
    int         low_w;
    int         period;
    int         errs;
    errs = err_cnt;
    bg_w = random_bits(32);
    axil_write(byte_addr(REG_BG), bg_w, 0);
    axil_write(byte_addr(REG_CTRL), 32'h1, 0);
    measure_sync(1'b0, low_w, period);
    check("hsync low", low_w, `VGA_H_SYNC);
    check("hsync period", period, LINE_CYCLES);
    measure_sync(1'b1, low_w, period);
    check("vsync low", low_w, `VGA_V_SYNC * LINE_CYCLES);
    check("vsync period", period, FRAME_CYCLES);
    scan_frame(1'b0, 12'h000, bg_w[11:0]);  // solid mode shows only bg
    report_test("sync timing", errs);
  endtask

  task automatic test_pixels();
    axil_data_t fg_w;
    axil_data_t bg_w;
    int         errs;
    errs = err_cnt;
    fg_w = random_bits(32);
    bg_w = random_bits(32);
    axil_write(byte_addr(REG_FG), fg_w, 0);
    axil_write(byte_addr(REG_BG), bg_w, 0);
    axil_write(byte_addr(REG_CTRL), 32'h3, 0);
    wait_sync_fall(1'b1);
    scan_frame(1'b1, fg_w[11:0], bg_w[11:0]);
    axil_write(byte_addr(REG_CTRL), 32'h1, 0);
    wait_sync_fall(1'b1);
    scan_frame(1'b0, fg_w[11:0], bg_w[11:0]);
    report_test("pixels", errs);
  endtask

  task automatic test_frame_count();
    axil_data_t  s0;
    axil_data_t  s1;
    int          falls0;
    int          falls1;
    logic [15:0] delta;
    int          errs;
    errs = err_cnt;
    while (!de) @(negedge clk_if);
    falls0 = vsync_falls;
    axil_read(byte_addr(REG_STATUS), 0, s0);
    wait_sync_fall(1'b1);
    wait_sync_fall(1'b1);
    while (!de) @(negedge clk_if);
    falls1 = vsync_falls;
    axil_read(byte_addr(REG_STATUS), 0, s1);
    delta = s1[15:0] - s0[15:0];
    check("frame count delta", 32'(delta), falls1 - falls0);
    report_test("frame count", errs);
  endtask

  initial begin
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(negedge clk_if);
    arst_n = 1'b1;
    test_readback();
    test_alias_status();
    test_backpressure();
    test_sync_timing();
    test_pixels();
    test_frame_count();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/vga_pkg.sv
axil/vga_axil_slave_fsm.sv
hdl/vga_regfile.sv
video/vga_timing.sv
video/vga_pixel_gen.sv
hdl/vga_axil_top.sv
testbench/tb_vga_axil_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the VGA AXI-Lite testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/100ps \
  --top-module tb_vga_axil_top \
  -f build.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
